//--- cpu_top.f
+incdir+verilog
verilog/cpu_pkg.sv
verilog/ctrl.sv
verilog/gpr.sv
verilog/if_stage.sv
verilog/id_stage.sv
verilog/ex_stage.sv
verilog/mem_stage.sv
verilog/cpu_top.sv
dv/tb_clk_gen.sv
dv/cpu_assert.sv
dv/tb_cpu.sv

//--- Bender.yml
package:
  name: cpu_top

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cpu_pkg.sv
      - verilog/ctrl.sv
      - verilog/gpr.sv
      - verilog/if_stage.sv
      - verilog/id_stage.sv
      - verilog/ex_stage.sv
      - verilog/mem_stage.sv
      - verilog/cpu_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/tb_clk_gen.sv
      - dv/cpu_assert.sv
      - dv/tb_cpu.sv

//--- dv/tb_cpu.sv
// Random-program testbench for the four-stage core
// Data-bus stores are checked in order against a sequential interpreter
// Both memories are word addressed with 64K words and no byte lanes
// Wait states 0 to 3 on both buses; all randomness from one seed

`timescale 1ns/1ns
`include "cpu_defs.svh"

module tb_cpu;
    import cpu_pkg::*;

    localparam int n_directed = 8;
    localparam int n_random   = 48;
    localparam int prog_len   = n_directed + n_random + `CPU_REG_NUM;
    localparam int mem_words  = 1 << `CPU_ADDR_W;
    localparam int wait_len   = 1024;                        // Wait-state table depth
    localparam int watchdog_ns = (prog_len + 20) * 10 * 8;

    logic                   clk;
    logic                   rst_n;
    logic [`CPU_DATA_W-1:0] iwb_dat;
    logic                   iwb_ack;
    logic                   iwb_cyc;
    logic                   iwb_stb;
    logic [`CPU_ADDR_W-1:0] iwb_adr;
    logic [`CPU_DATA_W-1:0] dwb_dat_r;
    logic                   dwb_ack;
    logic                   dwb_cyc;
    logic                   dwb_stb;
    logic                   dwb_we;
    logic [`CPU_ADDR_W-1:0] dwb_adr;
    logic [`CPU_DATA_W-1:0] dwb_dat_w;

    logic [`CPU_DATA_W-1:0] imem [prog_len];
    logic [`CPU_DATA_W-1:0] dmem [mem_words];      // Bus model view
    logic [`CPU_DATA_W-1:0] ref_mem [mem_words];   // Interpreter view
    int unsigned            i_wait_tab [wait_len];
    int unsigned            d_wait_tab [wait_len];
    logic [`CPU_ADDR_W-1:0] exp_adr [$];
    logic [`CPU_DATA_W-1:0] exp_dat [$];
    int                     exp_count;
    int                     n_stores;
    int                     errors;

    tb_clk_gen u_clk_gen (.clk, .rst_n);

    cpu_top dut0 (.*);

    function automatic logic [`CPU_DATA_W-1:0] encode_insn(input isa_op_e op,
            input logic [2:0] rd, input logic [2:0] ra, input logic [2:0] rb,
            input logic [15:0] imm);
        return {op, rd, ra, rb, 3'b000, imm};
    endfunction

    // Mostly r1..r3 to provoke hazards; r0 never a target so stays zero
    function automatic logic [2:0] pick_reg(input bit is_dst);
        if ($urandom_range(3, 0) != 0)
            return 3'($urandom_range(3, 1));
        return is_dst ? 3'($urandom_range(7, 1)) : 3'($urandom_range(7, 0));
    endfunction

    function automatic logic [`CPU_DATA_W-1:0] random_insn();
        int unsigned k;
        isa_op_e     op;
        k = $urandom_range(11, 0);
        if (k >= 9)
            op = (k == 11) ? ISA_OP_ST : ISA_OP_LD;   // Loads weighted up
        else
            op = isa_op_e'(k);
        return encode_insn(op, pick_reg(1'b1), pick_reg(1'b0), pick_reg(1'b0),
                           16'($urandom));
    endfunction

    task automatic build_program();
        imem[0] = encode_insn(ISA_OP_ADDI, 3'd1, 3'd0, 3'd0, 16'h0011);
        imem[1] = encode_insn(ISA_OP_ADDI, 3'd2, 3'd1, 3'd0, 16'h0005);  // EX fwd
        imem[2] = encode_insn(ISA_OP_ADD,  3'd3, 3'd1, 3'd2, 16'h0000);  // MEM and EX fwd
        imem[3] = encode_insn(ISA_OP_LD,   3'd1, 3'd3, 3'd0, 16'h0100);
        imem[4] = encode_insn(ISA_OP_ADD,  3'd2, 3'd1, 3'd3, 16'h0000);  // Load-use
        imem[5] = encode_insn(ISA_OP_LD,   3'd3, 3'd2, 3'd0, 16'h0200);
        imem[6] = encode_insn(ISA_OP_ST,   3'd0, 3'd1, 3'd3, 16'h0040);  // Late fwd
        imem[7] = encode_insn(ISA_OP_ST,   3'd0, 3'd0, 3'd2, 16'h0041);
        for (int i = 0; i < n_random; i++)
            imem[n_directed + i] = random_insn();
        for (int r = 0; r < `CPU_REG_NUM; r++)   // Dump every register at the end
            imem[n_directed + n_random + r] =
                encode_insn(ISA_OP_ST, 3'd0, 3'd0, 3'(r), 16'hff00 + 16'(r));
    endtask

    // Sequential ISA model that collects the expected stores
    task automatic run_reference();
        logic [`CPU_DATA_W-1:0] regs [`CPU_REG_NUM];
        logic [`CPU_DATA_W-1:0] w;
        logic [`CPU_DATA_W-1:0] a;
        logic [`CPU_DATA_W-1:0] b;
        logic [`CPU_DATA_W-1:0] imm;
        logic [`CPU_ADDR_W-1:0] adr;
        logic [3:0]             op;
        logic [2:0]             rd;
        for (int r = 0; r < `CPU_REG_NUM; r++)
            regs[r] = '0;
        for (int pc = 0; pc < prog_len; pc++) begin
            w   = imem[pc];
            op  = w[31:28];
            rd  = w[27:25];
            a   = regs[w[24:22]];
            b   = regs[w[21:19]];
            imm = {{16{w[15]}}, w[15:0]};
            adr = 16'(a + imm);
            case (op)
                ISA_OP_ADD:  regs[rd] = a + b;
                ISA_OP_SUB:  regs[rd] = a - b;
                ISA_OP_AND:  regs[rd] = a & b;
                ISA_OP_OR:   regs[rd] = a | b;
                ISA_OP_XOR:  regs[rd] = a ^ b;
                ISA_OP_ADDI: regs[rd] = a + imm;
                ISA_OP_LD:   regs[rd] = ref_mem[adr];
                ISA_OP_ST: begin
                    ref_mem[adr] = b;
                    exp_adr.push_back(adr);
                    exp_dat.push_back(b);
                end
                default: ;
            endcase
        end
    endtask

    task automatic check_store(input logic [`CPU_ADDR_W-1:0] adr,
                               input logic [`CPU_DATA_W-1:0] dat);
        logic [`CPU_ADDR_W-1:0] want_adr;
        logic [`CPU_DATA_W-1:0] want_dat;
        n_stores++;
        if (exp_adr.size() == 0) begin
            errors++;
            $display("Store %0d to 0x%h at %0t ns is beyond the reference program",
                     n_stores, adr, $time);
        end else begin
            want_adr = exp_adr.pop_front();
            want_dat = exp_dat.pop_front();
            if (adr !== want_adr) begin
                errors++;
                $display("** Error: dwb_adr = 0x%h, expected 0x%h (store %0d, %0t ns)",
                         adr, want_adr, n_stores, $time);
            end
            if (dat !== want_dat) begin
                errors++;
                $display("** Error: dwb_dat_w = 0x%h, expected 0x%h (store %0d, %0t ns)",
                         dat, want_dat, n_stores, $time);
            end
        end
    endtask

    // Buses idle at release and first fetch from 0 one cycle later
    task automatic check_reset_idle();
        @(posedge rst_n);
        if (iwb_cyc !== 1'b0 || iwb_stb !== 1'b0 || dwb_cyc !== 1'b0 || dwb_stb !== 1'b0) begin
            errors++;
            $display("A bus cycle is active at reset release");
        end
        @(posedge clk);
        #1;
        if (iwb_cyc !== 1'b1 || iwb_stb !== 1'b1) begin
            errors++;
            $display("First fetch did not start one cycle after reset");
        end
        if (iwb_adr !== '0) begin
            errors++;
            $display("** Error: iwb_adr = 0x%h, expected 0x%h", iwb_adr, 16'h0000);
        end
    endtask

    // Instruction slave returning NOP past the end of the program
    initial begin : ibus_model
        int wait_left;
        int xfers;
        iwb_ack   = 1'b0;
        iwb_dat   = '0;
        wait_left = -1;
        xfers     = 0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && iwb_cyc && iwb_stb) begin
                if (wait_left < 0) begin
                    wait_left = i_wait_tab[xfers % wait_len];   // New transfer
                    xfers++;
                end
                if (wait_left == 0) begin
                    iwb_ack   = 1'b1;
                    iwb_dat   = (iwb_adr < prog_len) ? imem[iwb_adr] : '0;
                    wait_left = -1;
                end else begin
                    iwb_ack = 1'b0;
                    wait_left--;
                end
            end else begin
                iwb_ack   = 1'b0;
                wait_left = -1;
            end
        end
    end

    // Data slave that checks each write as it is acked
    initial begin : dbus_model
        int wait_left;
        int xfers;
        dwb_ack   = 1'b0;
        dwb_dat_r = '0;
        wait_left = -1;
        xfers     = 0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && dwb_cyc && dwb_stb) begin
                if (wait_left < 0) begin
                    wait_left = d_wait_tab[xfers % wait_len];
                    xfers++;
                end
                if (wait_left == 0) begin
                    dwb_ack   = 1'b1;
                    wait_left = -1;
                    if (dwb_we) begin
                        check_store(dwb_adr, dwb_dat_w);
                        dmem[dwb_adr] = dwb_dat_w;
                    end else begin
                        dwb_dat_r = dmem[dwb_adr];
                    end
                end else begin
                    dwb_ack = 1'b0;
                    wait_left--;
                end
            end else begin
                dwb_ack   = 1'b0;
                wait_left = -1;
            end
        end
    end

    initial begin : watchdog
        #(watchdog_ns);
        $display("Timeout after %0d ns: %0d of %0d stores seen, %0d errors",
                 watchdog_ns, n_stores, exp_count, errors);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : main
        errors    = 0;
        n_stores  = 0;
        exp_count = 0;
        void'($urandom(32'hb45c7338));
        for (int i = 0; i < wait_len; i++) begin
            i_wait_tab[i] = $urandom_range(3, 0);
            d_wait_tab[i] = $urandom_range(3, 0);
        end
        for (int a = 0; a < mem_words; a++) begin
            dmem[a]    = $urandom;
            ref_mem[a] = dmem[a];
        end
        build_program();
        run_reference();
        exp_count = exp_adr.size();
        check_reset_idle();
        wait (n_stores >= exp_count);
        repeat (20) @(posedge clk);   // Room for a stray extra store
        if (n_stores != exp_count) begin
            errors++;
            $display("Store count is %0d but the reference program made %0d",
                     n_stores, exp_count);
        end
        errors += dut0.u_cpu_assert.n_fail;   // Bound protocol and freeze checks
        $display("Run done: %0d of %0d stores seen, %0d errors", n_stores, exp_count, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- dv/cpu_assert.sv
// Wishbone classic protocol and pipeline freeze checks bound into cpu_top
// Checks are off while rst_n is low

`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_assert (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   iwb_cyc,
    input logic                   iwb_stb,
    input logic [`CPU_ADDR_W-1:0] iwb_adr,
    input logic                   iwb_ack,
    input logic                   dwb_cyc,
    input logic                   dwb_stb,
    input logic                   dwb_we,
    input logic [`CPU_ADDR_W-1:0] dwb_adr,
    input logic [`CPU_DATA_W-1:0] dwb_dat_w,
    input logic                   dwb_ack,
    input logic                   if_busy,    // Internal stage signals
    input logic                   mem_busy,
    input logic                   if_en,
    input logic                   id_en,
    input logic                   ex_en
);
    int n_fail = 0;   // Failed checks so far

    a_istb_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        iwb_stb |-> iwb_cyc)
        else begin
            n_fail++;
            $error("iwb_stb high without iwb_cyc");
        end

    a_dstb_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        dwb_stb |-> dwb_cyc)
        else begin
            n_fail++;
            $error("dwb_stb high without dwb_cyc");
        end

    // Request held until the slave acks
    a_iwb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (iwb_stb && !iwb_ack) |=> (iwb_stb && $stable(iwb_adr)))
        else begin
            n_fail++;
            $error("instruction request changed before ack");
        end

    a_dwb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (dwb_stb && !dwb_ack) |=>
            (dwb_stb && $stable(dwb_adr) && $stable(dwb_we) && $stable(dwb_dat_w)))
        else begin
            n_fail++;
            $error("data request changed before ack");
        end

    // A bus wait state holds every valid bit and lets no bubble in
    a_busy_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        (if_busy || mem_busy) |=> ($stable(if_en) && $stable(id_en) && $stable(ex_en)))
        else begin
            n_fail++;
            $error("pipeline advanced or took a bubble during a bus wait state");
        end

endmodule

bind cpu_top cpu_assert u_cpu_assert (.*);

//--- dv/tb_clk_gen.sv
// Clock and reset source for the core testbench
// 8 ns period, rst_n low for the first 8 rising edges
// Release lands 1 ns after an edge, like every other driven input

`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    localparam int half_period = 4;
    localparam int rst_cycles  = 8;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        #1 rst_n = 1'b1;    // Sync reset, sampled high from the next edge
    end

endmodule

//--- verilog/cpu_top.sv
// Four-stage core top, IF, ID, EX and MEM with write-back
// Two Wishbone classic masters, word addressed, no interrupts

`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CPU_DATA_W-1:0] iwb_dat,
    input  logic                   iwb_ack,
    input  logic [`CPU_DATA_W-1:0] dwb_dat_r,
    input  logic                   dwb_ack,
    output logic                   iwb_cyc,
    output logic                   iwb_stb,
    output logic [`CPU_ADDR_W-1:0] iwb_adr,
    output logic                   dwb_cyc,
    output logic                   dwb_stb,
    output logic                   dwb_we,
    output logic [`CPU_ADDR_W-1:0] dwb_adr,
    output logic [`CPU_DATA_W-1:0] dwb_dat_w
);
    import cpu_pkg::*;

    // Stall and flush
    logic if_stall, id_stall, ex_stall, mem_stall, id_flush;
    logic if_busy, mem_busy;

    // IF/ID
    logic [`CPU_DATA_W-1:0] if_insn;
    logic                   if_en;

    // Decode and ID/EX
    isa_op_e                op;
    logic [`CPU_REG_AW-1:0] ra_addr, rb_addr, id_dst_addr, id_rb_addr;
    logic [1:0]             src_reg_used;
    logic                   id_en, id_gpr_we;
    mem_op_e                id_mem_op;
    alu_op_e                id_alu_op;
    logic [`CPU_DATA_W-1:0] id_opa, id_opb, id_store_data;
    logic [`CPU_DATA_W-1:0] ra_data, rb_data;

    // EX/MEM and results
    logic [`CPU_DATA_W-1:0] ex_result, ex_alu_q, ex_store_data, mem_result;
    logic                   ex_en, ex_gpr_we;
    logic [`CPU_REG_AW-1:0] ex_dst_addr;
    mem_op_e                ex_mem_op;

    // Forwarding and write-back
    fwd_ctrl_e              ra_fwd_ctrl, rb_fwd_ctrl;
    logic                   ex_rb_fwd_en;
    logic                   gpr_we;
    logic [`CPU_REG_AW-1:0] gpr_wr_addr;
    logic [`CPU_DATA_W-1:0] gpr_wr_data;

    ctrl u_ctrl (.*);

    gpr u_gpr (
        .clk, .rst_n, .ra_addr, .rb_addr,
        .we(gpr_we), .wr_addr(gpr_wr_addr), .wr_data(gpr_wr_data),
        .ra_data, .rb_data
    );

    if_stage u_if_stage (.*);
    id_stage u_id_stage (.*);
    ex_stage u_ex_stage (.*);
    mem_stage u_mem_stage (.*);

endmodule

//--- verilog/mem_stage.sv
// Memory and write-back stage with a Wishbone classic data master
// Word access only, no error or retry. An ack that lands during a
// stall is remembered so the access is not repeated

`timescale 1ns/1ns
`include "cpu_defs.svh"

module mem_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mem_stall,
    input  logic                   ex_en,
    input  logic [`CPU_REG_AW-1:0] ex_dst_addr,
    input  logic                   ex_gpr_we,
    input  cpu_pkg::mem_op_e       ex_mem_op,
    input  logic [`CPU_DATA_W-1:0] ex_alu_q,
    input  logic [`CPU_DATA_W-1:0] ex_store_data,
    input  logic [`CPU_DATA_W-1:0] dwb_dat_r,
    input  logic                   dwb_ack,
    output logic                   dwb_cyc,
    output logic                   dwb_stb,
    output logic                   dwb_we,
    output logic [`CPU_ADDR_W-1:0] dwb_adr,
    output logic [`CPU_DATA_W-1:0] dwb_dat_w,
    output logic                   mem_busy,
    output logic [`CPU_DATA_W-1:0] mem_result,
    output logic                   gpr_we,
    output logic [`CPU_REG_AW-1:0] gpr_wr_addr,
    output logic [`CPU_DATA_W-1:0] gpr_wr_data
);
    import cpu_pkg::*;

    logic                   done;     // Access acked, insn still held
    logic [`CPU_DATA_W-1:0] ld_q;     // Load data kept while held

    // EX/MEM is frozen during the access, so bus lines stay stable
    assign dwb_cyc   = ex_en & (ex_mem_op != MEM_OP_NONE) & ~done;
    assign dwb_stb   = dwb_cyc;
    assign dwb_we    = (ex_mem_op == MEM_OP_ST);
    assign dwb_adr   = ex_alu_q[`CPU_ADDR_W-1:0];
    assign dwb_dat_w = ex_store_data;
    assign mem_busy  = dwb_cyc & ~dwb_ack;

    always_ff @(posedge clk) begin
        if (!rst_n || !mem_stall)
            done <= 1'b0;             // Insn retires on this edge
        else if (dwb_cyc && dwb_ack)
            done <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (dwb_cyc && dwb_ack)
            ld_q <= dwb_dat_r;
    end

    always_comb begin
        if (ex_mem_op == MEM_OP_LD)
            mem_result = done ? ld_q : dwb_dat_r;
        else
            mem_result = ex_alu_q;
    end

    // Load not yet acked keeps mem_stall high
    assign gpr_we      = ex_en & ex_gpr_we & ~mem_stall;
    assign gpr_wr_addr = ex_dst_addr;
    assign gpr_wr_data = mem_result;

endmodule

//--- verilog/ex_stage.sv
// Execute stage, ALU and EX/MEM register
// Store data from a load one ahead is patched in here from MEM

`timescale 1ns/1ns
`include "cpu_defs.svh"

module ex_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ex_stall,
    input  logic                   id_en,
    input  cpu_pkg::alu_op_e       id_alu_op,
    input  logic [`CPU_DATA_W-1:0] id_opa,
    input  logic [`CPU_DATA_W-1:0] id_opb,
    input  logic [`CPU_DATA_W-1:0] id_store_data,
    input  logic [`CPU_REG_AW-1:0] id_dst_addr,
    input  logic                   id_gpr_we,
    input  cpu_pkg::mem_op_e       id_mem_op,
    input  logic                   ex_rb_fwd_en,
    input  logic [`CPU_DATA_W-1:0] mem_result,
    output logic [`CPU_DATA_W-1:0] ex_result,     // To ID for EX forwarding
    output logic                   ex_en,
    output logic [`CPU_REG_AW-1:0] ex_dst_addr,
    output logic                   ex_gpr_we,
    output cpu_pkg::mem_op_e       ex_mem_op,
    output logic [`CPU_DATA_W-1:0] ex_alu_q,
    output logic [`CPU_DATA_W-1:0] ex_store_data
);
    import cpu_pkg::*;

    always_comb begin
        case (id_alu_op)
            ALU_OP_SUB: ex_result = id_opa - id_opb;
            ALU_OP_AND: ex_result = id_opa & id_opb;
            ALU_OP_OR:  ex_result = id_opa | id_opb;
            ALU_OP_XOR: ex_result = id_opa ^ id_opb;
            default:    ex_result = id_opa + id_opb;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_en     <= 1'b0;
            ex_gpr_we <= 1'b0;
            ex_mem_op <= MEM_OP_NONE;
        end else if (!ex_stall) begin
            ex_en     <= id_en;
            ex_gpr_we <= id_gpr_we;
            ex_mem_op <= id_mem_op;
        end
    end

    always_ff @(posedge clk) begin
        if (!ex_stall) begin
            ex_dst_addr   <= id_dst_addr;
            ex_alu_q      <= ex_result;     // Result or bus address
            ex_store_data <= ex_rb_fwd_en ? mem_result : id_store_data;
        end
    end

endmodule

//--- verilog/id_stage.sv
// Decode and register read stage, ID/EX register at the output
// Undefined opcodes and empty IF/ID slots decode as NOP
// Immediate replaces operand B for ADDI, LD and ST

`timescale 1ns/1ns
`include "cpu_defs.svh"

module id_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CPU_DATA_W-1:0] if_insn,
    input  logic                   if_en,
    input  logic                   id_stall,
    input  logic                   id_flush,
    input  cpu_pkg::fwd_ctrl_e     ra_fwd_ctrl,
    input  cpu_pkg::fwd_ctrl_e     rb_fwd_ctrl,
    input  logic [`CPU_DATA_W-1:0] ra_data,
    input  logic [`CPU_DATA_W-1:0] rb_data,
    input  logic [`CPU_DATA_W-1:0] ex_result,
    input  logic [`CPU_DATA_W-1:0] mem_result,
    output cpu_pkg::isa_op_e       op,
    output logic [`CPU_REG_AW-1:0] ra_addr,
    output logic [`CPU_REG_AW-1:0] rb_addr,
    output logic [1:0]             src_reg_used,
    output logic                   id_en,
    output logic [`CPU_REG_AW-1:0] id_dst_addr,
    output logic                   id_gpr_we,
    output cpu_pkg::mem_op_e       id_mem_op,
    output logic [`CPU_REG_AW-1:0] id_rb_addr,
    output cpu_pkg::alu_op_e       id_alu_op,
    output logic [`CPU_DATA_W-1:0] id_opa,
    output logic [`CPU_DATA_W-1:0] id_opb,
    output logic [`CPU_DATA_W-1:0] id_store_data
);
    import cpu_pkg::*;

    insn_t                  insn;
    logic [`CPU_DATA_W-1:0] imm_ext;
    logic [`CPU_DATA_W-1:0] ra_val;
    logic [`CPU_DATA_W-1:0] rb_val;
    alu_op_e                alu_op;
    mem_op_e                mem_op;
    logic                   gpr_we;
    logic                   use_imm;

    function automatic logic [`CPU_DATA_W-1:0] fwd_mux(input fwd_ctrl_e sel,
                                                     input logic [`CPU_DATA_W-1:0] rf);
        case (sel)
            FWD_CTRL_EX:  return ex_result;
            FWD_CTRL_MEM: return mem_result;
            default:      return rf;
        endcase
    endfunction

    assign insn    = insn_t'(if_insn);
    assign op      = if_en ? insn.op : ISA_OP_NOP;
    assign ra_addr = insn.ra;
    assign rb_addr = insn.rb;
    assign imm_ext = {{(`CPU_DATA_W-`CPU_IMM_W){insn.imm[`CPU_IMM_W-1]}}, insn.imm};

    always_comb begin
        alu_op       = ALU_OP_ADD;   // Also address add for LD and ST
        mem_op       = MEM_OP_NONE;
        gpr_we       = 1'b0;
        use_imm      = 1'b0;
        src_reg_used = 2'b00;
        case (op)
            ISA_OP_ADD, ISA_OP_SUB, ISA_OP_AND, ISA_OP_OR, ISA_OP_XOR: begin
                gpr_we       = 1'b1;
                src_reg_used = 2'b11;
            end
            ISA_OP_ADDI, ISA_OP_LD: begin
                gpr_we       = 1'b1;
                use_imm      = 1'b1;
                src_reg_used = 2'b01;
            end
            ISA_OP_ST: begin
                use_imm      = 1'b1;
                src_reg_used = 2'b11;   // rb is the store data
            end
            default: ;
        endcase
        if (op == ISA_OP_LD)
            mem_op = MEM_OP_LD;
        if (op == ISA_OP_ST)
            mem_op = MEM_OP_ST;
        case (op)
            ISA_OP_SUB: alu_op = ALU_OP_SUB;
            ISA_OP_AND: alu_op = ALU_OP_AND;
            ISA_OP_OR:  alu_op = ALU_OP_OR;
            ISA_OP_XOR: alu_op = ALU_OP_XOR;
            default:    ;
        endcase
    end

    assign ra_val = fwd_mux(ra_fwd_ctrl, ra_data);
    assign rb_val = fwd_mux(rb_fwd_ctrl, rb_data);

    always_ff @(posedge clk) begin
        if (!rst_n || id_flush) begin
            id_en     <= 1'b0;          // Bubble
            id_gpr_we <= 1'b0;
            id_mem_op <= MEM_OP_NONE;
        end else if (!id_stall) begin
            id_en     <= if_en;
            id_gpr_we <= gpr_we;
            id_mem_op <= mem_op;
        end
    end

    always_ff @(posedge clk) begin
        if (!id_stall) begin
            id_dst_addr   <= insn.rd;
            id_rb_addr    <= insn.rb;
            id_alu_op     <= alu_op;
            id_opa        <= ra_val;
            id_opb        <= use_imm ? imm_ext : rb_val;
            id_store_data <= rb_val;    // May be replaced in EX by late forward
        end
    end

endmodule

//--- verilog/if_stage.sv
// Fetch stage with a Wishbone classic instruction master
// One fetch in flight; a word acked during a stall waits in a holding
// register. First fetch is from word address 0, one cycle after reset

`timescale 1ns/1ns
`include "cpu_defs.svh"

module if_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   if_stall,
    input  logic [`CPU_DATA_W-1:0] iwb_dat,
    input  logic                   iwb_ack,
    output logic                   iwb_cyc,
    output logic                   iwb_stb,
    output logic [`CPU_ADDR_W-1:0] iwb_adr,
    output logic                   if_busy,
    output logic [`CPU_DATA_W-1:0] if_insn,   // IF/ID register
    output logic                   if_en
);
    logic [`CPU_ADDR_W-1:0] pc;
    logic                   pend;                  // Acked word not yet taken
    logic [`CPU_DATA_W-1:0] pend_dat;
    logic                   word_vld;
    logic [`CPU_DATA_W-1:0] word;

    assign word_vld = (iwb_cyc & iwb_ack) | pend;
    assign word     = pend ? pend_dat : iwb_dat;
    assign iwb_stb  = iwb_cyc;
    assign iwb_adr  = pc;
    assign if_busy  = iwb_cyc & ~iwb_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc      <= '0;
            pend    <= 1'b0;
            iwb_cyc <= 1'b0;
            if_en   <= 1'b0;
        end else begin
            if (!if_stall)
                if_en <= word_vld;          // Bubble when nothing fetched
            if (iwb_cyc && iwb_ack) begin
                if (if_stall) begin
                    pend    <= 1'b1;        // Park word, drop the cycle
                    iwb_cyc <= 1'b0;
                end else begin
                    pc <= pc + 1'b1;        // Next fetch back to back
                end
            end else if (pend && !if_stall) begin
                pend    <= 1'b0;
                pc      <= pc + 1'b1;
                iwb_cyc <= 1'b1;
            end else if (!iwb_cyc && !pend) begin
                iwb_cyc <= 1'b1;            // First fetch after reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (iwb_cyc && iwb_ack && if_stall)
            pend_dat <= iwb_dat;
        if (!if_stall)
            if_insn <= word;
    end

endmodule

//--- verilog/gpr.sv
// Register file, two async read ports and one sync write port
// A write is not visible on the read ports until the next cycle

`timescale 1ns/1ns
`include "cpu_defs.svh"

module gpr (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CPU_REG_AW-1:0] ra_addr,
    input  logic [`CPU_REG_AW-1:0] rb_addr,
    input  logic                   we,
    input  logic [`CPU_REG_AW-1:0] wr_addr,
    input  logic [`CPU_DATA_W-1:0] wr_data,
    output logic [`CPU_DATA_W-1:0] ra_data,
    output logic [`CPU_DATA_W-1:0] rb_data
);
    logic [`CPU_DATA_W-1:0] regs [`CPU_REG_NUM];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_REG_NUM; i++)
                regs[i] <= '0;    // All registers start at zero
        end else if (we) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign ra_data = regs[ra_addr];
    assign rb_data = regs[rb_addr];

endmodule

//--- verilog/ctrl.sv
// Hazard and forwarding control, purely combinational
// Straight-line code only, no branch hazards
// A bus wait state on either port freezes every stage

`timescale 1ns/1ns
`include "cpu_defs.svh"

module ctrl (
    input  logic [1:0]             src_reg_used,  // bit0 ra, bit1 rb
    input  cpu_pkg::isa_op_e       op,
    input  logic [`CPU_REG_AW-1:0] ra_addr,
    input  logic [`CPU_REG_AW-1:0] rb_addr,
    input  logic                   id_en,         // ID/EX contents, insn in EX
    input  logic [`CPU_REG_AW-1:0] id_dst_addr,
    input  logic                   id_gpr_we,
    input  cpu_pkg::mem_op_e       id_mem_op,
    input  logic [`CPU_REG_AW-1:0] id_rb_addr,
    input  logic                   ex_en,         // EX/MEM contents, insn in MEM
    input  logic [`CPU_REG_AW-1:0] ex_dst_addr,
    input  logic                   ex_gpr_we,
    input  cpu_pkg::mem_op_e       ex_mem_op,
    input  logic                   if_busy,
    input  logic                   mem_busy,
    output logic                   if_stall,
    output logic                   id_stall,
    output logic                   ex_stall,
    output logic                   mem_stall,
    output logic                   id_flush,
    output cpu_pkg::fwd_ctrl_e     ra_fwd_ctrl,
    output cpu_pkg::fwd_ctrl_e     rb_fwd_ctrl,
    output logic                   ex_rb_fwd_en
);
    import cpu_pkg::*;

    logic busy;
    logic ld_hazard;

    // Youngest writer wins, EX before MEM
    function automatic fwd_ctrl_e fwd_sel(input logic used,
                                          input logic [`CPU_REG_AW-1:0] addr);
        if (used && id_en && id_gpr_we && (id_dst_addr == addr))
            return FWD_CTRL_EX;
        if (used && ex_en && ex_gpr_we && (ex_dst_addr == addr))
            return FWD_CTRL_MEM;
        return FWD_CTRL_NONE;
    endfunction

    assign ra_fwd_ctrl = fwd_sel(src_reg_used[0], ra_addr);
    assign rb_fwd_ctrl = fwd_sel(src_reg_used[1], rb_addr);

    // Load in MEM feeding store data of the store in EX
    assign ex_rb_fwd_en = ex_en && ex_gpr_we && (ex_mem_op == MEM_OP_LD) &&
                          id_en && (id_mem_op == MEM_OP_ST) &&
                          (ex_dst_addr == id_rb_addr);

    // Load in EX, consumer in ID; a store matching only on rb is left
    // to the late forward above
    assign ld_hazard = id_en && id_gpr_we && (id_mem_op == MEM_OP_LD) &&
                       ((src_reg_used[0] && (id_dst_addr == ra_addr)) ||
                        (src_reg_used[1] && (id_dst_addr == rb_addr) &&
                         (op != ISA_OP_ST)));

    assign busy      = if_busy | mem_busy;   // Either bus in wait state
    assign if_stall  = busy | ld_hazard;     // Hold PC and IF/ID
    assign id_stall  = busy;
    assign ex_stall  = busy;
    assign mem_stall = busy;
    assign id_flush  = ld_hazard & ~busy;    // Bubble into ID/EX

endmodule

//--- verilog/cpu_pkg.sv
// Opcode, ALU, memory and forwarding encodings of the core
// Opcodes 9 to 15 are not defined and decode as NOP

`include "cpu_defs.svh"

package cpu_pkg;

    typedef enum logic [3:0] {
        ISA_OP_NOP  = 4'd0,
        ISA_OP_ADD  = 4'd1,
        ISA_OP_SUB  = 4'd2,
        ISA_OP_AND  = 4'd3,
        ISA_OP_OR   = 4'd4,
        ISA_OP_XOR  = 4'd5,
        ISA_OP_ADDI = 4'd6,   // rd = ra + imm
        ISA_OP_LD   = 4'd7,   // rd = mem[ra + imm]
        ISA_OP_ST   = 4'd8    // mem[ra + imm] = rb
    } isa_op_e;

    typedef enum logic [2:0] {
        ALU_OP_ADD, ALU_OP_SUB, ALU_OP_AND, ALU_OP_OR, ALU_OP_XOR
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_OP_NONE, MEM_OP_LD, MEM_OP_ST
    } mem_op_e;

    // Operand source picked in ID
    typedef enum logic [1:0] {
        FWD_CTRL_NONE,  // Register file
        FWD_CTRL_EX,    // ALU result of insn in EX
        FWD_CTRL_MEM    // Result of insn in MEM
    } fwd_ctrl_e;

    // Field order, MSB first
    typedef struct packed {
        isa_op_e                op;
        logic [`CPU_REG_AW-1:0] rd;
        logic [`CPU_REG_AW-1:0] ra;
        logic [`CPU_REG_AW-1:0] rb;
        logic [2:0]             rsvd;   // Unused
        logic [`CPU_IMM_W-1:0]  imm;
    } insn_t;

endpackage

//--- verilog/cpu_defs.svh
// Core width macros shared by the package and all RTL
// Addresses are word addresses, no byte lanes
// Immediate is sign-extended to the data width

`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data and instruction word
`define CPU_DATA_W 32

// Word address on both buses
`define CPU_ADDR_W 16

// Register file index and depth
`define CPU_REG_AW 3
`define CPU_REG_NUM 8

// Immediate field of the instruction
`define CPU_IMM_W 16

`endif
